//--- hdl/unicore_pkg.sv
package unicore_pkg;

  localparam int paddr_width_lp  = 32;
  localparam int data_width_lp   = 64;
  localparam int lce_id_width_lp = 2;

  // Requesters, in rising arbitration priority
  localparam int num_req_lp    = 3;
  localparam int req_icache_lp = 0;
  localparam int req_dcache_lp = 1;
  localparam int req_io_lp     = 2;

  localparam int num_dev_lp = 5;

  typedef enum logic [1:0]
  {
    e_mem_rd = 2'b00
    , e_mem_wr = 2'b01
  } msg_type_e;

  typedef struct packed
  {
    msg_type_e                  msg_type;
    logic [paddr_width_lp-1:0]  addr;
    logic [lce_id_width_lp-1:0] lce_id;
    logic [data_width_lp-1:0]   data;
  } mem_msg_t;

  // Local memory map
  localparam logic [paddr_width_lp-1:0] dram_base_lp = 32'h8000_0000;
  localparam int dev_lsb_lp = 20;

  localparam logic [3:0] boot_dev_lp  = 4'd0;
  localparam logic [3:0] clint_dev_lp = 4'd1;
  localparam logic [3:0] cfg_dev_lp   = 4'd2;
  localparam logic [3:0] host_dev_lp  = 4'd3;
  localparam logic [3:0] cache_dev_lp = 4'd4;

  localparam logic [15:0] cfg_freeze_off_lp     = 16'h0000;
  localparam logic [15:0] clint_msip_off_lp     = 16'h0000;
  localparam logic [15:0] clint_mtimecmp_off_lp = 16'h4000;
  localparam logic [15:0] clint_mtime_off_lp    = 16'hBFF8;

  // Command targets; the index order is also the response priority, highest last
  typedef enum logic [2:0]
  {
    e_dev_cfg = 3'd0
    , e_dev_clint = 3'd1
    , e_dev_io = 3'd2
    , e_dev_mem = 3'd3
    , e_dev_loopback = 3'd4
  } dev_e;

endpackage

//--- hdl/two_fifo.sv
`timescale 1ns/1ps

module two_fifo
  import unicore_pkg::*;
(
  input  logic     clk_i
  , input  logic     rst_i

  , input  mem_msg_t data_i
  , input  logic     v_i
  , output logic     ready_o

  , output mem_msg_t data_o
  , output logic     v_o
  , input  logic     yumi_i
);

  mem_msg_t mem_r [0:1];
  logic     wr_ptr_r, rd_ptr_r;
  logic     full_r, empty_r;
  logic     enq, deq;

  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= ~wr_ptr_r;
      if (deq)
        rd_ptr_r <= ~rd_ptr_r;
      // Occupancy only moves when exactly one side fires
      if (enq && !deq)
      begin
        empty_r <= 1'b0;
        full_r  <= ~empty_r;
      end
      else if (deq && !enq)
      begin
        full_r  <= 1'b0;
        empty_r <= ~full_r;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wr_ptr_r] <= data_i;
  end

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> v_o);

endmodule

//--- hdl/cmd_router.sv
`timescale 1ns/1ps

module cmd_router
  import unicore_pkg::*;
(
  input  logic                      clk_i
  , input  logic                      rst_i

  , input  mem_msg_t [num_req_lp-1:0] head_i
  , input  logic [num_req_lp-1:0]     head_v_i
  , output logic [num_req_lp-1:0]     head_yumi_o

  , input  logic [num_dev_lp-1:0]     dev_ready_i
  , output mem_msg_t                  cmd_o
  , output logic [num_dev_lp-1:0]     dev_v_o
);

  logic                       all_ready;
  logic                       granted;
  logic [$bits(mem_msg_t)-1:0] sel_bits;
  logic                       local_cmd;
  logic [3:0]                 dev_field;
  logic [num_dev_lp-1:0]      dev_sel;

  // One blocked target holds off every requester
  assign all_ready = &dev_ready_i;

  // Fixed priority: io, then dcache, then icache
  assign head_yumi_o[req_io_lp]     = all_ready & head_v_i[req_io_lp];
  assign head_yumi_o[req_dcache_lp] = all_ready & head_v_i[req_dcache_lp]
                                    & ~head_v_i[req_io_lp];
  assign head_yumi_o[req_icache_lp] = all_ready & head_v_i[req_icache_lp]
                                    & ~head_v_i[req_dcache_lp] & ~head_v_i[req_io_lp];

  assign granted = |head_yumi_o;

  // One-hot mux of the granted head
  always_comb
  begin
    sel_bits = '0;
    for (int i = 0; i < num_req_lp; i++)
    begin
      sel_bits = sel_bits | ({$bits(mem_msg_t){head_yumi_o[i]}} & head_i[i]);
    end
  end

  assign cmd_o = mem_msg_t'(sel_bits);

  assign local_cmd = (cmd_o.addr < dram_base_lp);
  assign dev_field = cmd_o.addr[dev_lsb_lp +: 4];

  always_comb
  begin
    dev_sel = '0;
    if (!local_cmd)
      dev_sel[e_dev_mem] = 1'b1;
    else
    begin
      case (dev_field)
        cfg_dev_lp:                dev_sel[e_dev_cfg]      = 1'b1;
        clint_dev_lp:              dev_sel[e_dev_clint]    = 1'b1;
        boot_dev_lp, host_dev_lp:  dev_sel[e_dev_io]       = 1'b1;
        cache_dev_lp:              dev_sel[e_dev_mem]      = 1'b1;
        default:                   dev_sel[e_dev_loopback] = 1'b1;
      endcase
    end
  end

  assign dev_v_o = dev_sel & {num_dev_lp{granted}};

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(head_yumi_o));

  // A granted command reaches exactly one target
  a_one_target: assert property (@(posedge clk_i) disable iff (rst_i)
    granted |-> $onehot(dev_v_o));

endmodule

//--- hdl/resp_router.sv
`timescale 1ns/1ps

module resp_router
  import unicore_pkg::*;
(
  input  logic                      clk_i
  , input  logic                      rst_i

  , input  mem_msg_t [num_dev_lp-1:0] dev_resp_i
  , input  logic [num_dev_lp-1:0]     dev_resp_v_i
  , output logic [num_dev_lp-1:0]     dev_resp_yumi_o

  , input  logic [num_req_lp-1:0]     queue_ready_i
  , output mem_msg_t                  resp_o
  , output logic [num_req_lp-1:0]     queue_v_o
);

  logic                        all_ready;
  logic                        granted;
  logic [$bits(mem_msg_t)-1:0] sel_bits;

  // A full response queue stalls every target
  assign all_ready = &queue_ready_i;

  // Highest index wins: loopback, mem, io, clint, cfg
  always_comb
  begin
    logic found;
    found           = 1'b0;
    dev_resp_yumi_o = '0;
    for (int i = num_dev_lp-1; i >= 0; i--)
    begin
      if (dev_resp_v_i[i] && !found)
      begin
        dev_resp_yumi_o[i] = all_ready;
        found              = 1'b1;
      end
    end
  end

  assign granted = |dev_resp_yumi_o;

  always_comb
  begin
    sel_bits = '0;
    for (int i = 0; i < num_dev_lp; i++)
    begin
      sel_bits = sel_bits | ({$bits(mem_msg_t){dev_resp_yumi_o[i]}} & dev_resp_i[i]);
    end
  end

  assign resp_o = mem_msg_t'(sel_bits);

  for (genvar q = 0; q < num_req_lp; q++)
  begin : steer
    assign queue_v_o[q] = granted & (resp_o.lce_id == lce_id_width_lp'(q));
  end

  // Targets must echo a requester id that exists
  a_lce_id_range: assert property (@(posedge clk_i) disable iff (rst_i)
    granted |-> (resp_o.lce_id < num_req_lp));

endmodule

//--- hdl/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs
  import unicore_pkg::*;
(
  input  logic     clk_i
  , input  logic     rst_i

  , input  mem_msg_t cmd_i
  , input  logic     cmd_v_i
  , output logic     cmd_ready_o

  , output mem_msg_t resp_o
  , output logic     resp_v_o
  , input  logic     resp_yumi_i

  , output logic     freeze_o
);

  logic     freeze_r;
  logic     resp_v_r;
  mem_msg_t resp_r;
  logic     cmd_fire;
  logic     is_write;
  logic     is_freeze;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_i.msg_type == e_mem_wr);
  assign is_freeze   = (cmd_i.addr[15:0] == cfg_freeze_off_lp);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_r <= 1'b0;
      // Core comes out of reset held in freeze
      freeze_r <= 1'b1;
    end
    else
    begin
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
      if (cmd_fire && is_write && is_freeze)
        freeze_r <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.msg_type <= cmd_i.msg_type;
      resp_r.addr     <= cmd_i.addr;
      resp_r.lce_id   <= cmd_i.lce_id;
      resp_r.data     <= (!is_write && is_freeze) ? data_width_lp'(freeze_r) : '0;
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;
  assign freeze_o = freeze_r;

endmodule

//--- hdl/clint_slice.sv
`timescale 1ns/1ps

module clint_slice
  import unicore_pkg::*;
(
  input  logic     clk_i
  , input  logic     rst_i

  , input  mem_msg_t cmd_i
  , input  logic     cmd_v_i
  , output logic     cmd_ready_o

  , output mem_msg_t resp_o
  , output logic     resp_v_o
  , input  logic     resp_yumi_i

  , output logic     timer_irq_o
  , output logic     software_irq_o
);

  logic [data_width_lp-1:0] mtime_r;
  logic [data_width_lp-1:0] mtimecmp_r;
  logic                     msip_r;
  logic                     resp_v_r;
  mem_msg_t                 resp_r;
  logic                     cmd_fire;
  logic                     is_write;
  logic [15:0]              offset;
  logic [data_width_lp-1:0] rd_data;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign is_write    = (cmd_i.msg_type == e_mem_wr);
  assign offset      = cmd_i.addr[15:0];

  always_comb
  begin
    case (offset)
      clint_msip_off_lp:     rd_data = data_width_lp'(msip_r);
      clint_mtimecmp_off_lp: rd_data = mtimecmp_r;
      clint_mtime_off_lp:    rd_data = mtime_r;
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      mtime_r    <= '0;
      // All ones keeps the timer interrupt quiet until software programs it
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
      resp_v_r   <= 1'b0;
    end
    else
    begin
      mtime_r <= mtime_r + 1'b1;
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
      if (cmd_fire && is_write && offset == clint_msip_off_lp)
        msip_r <= cmd_i.data[0];
      if (cmd_fire && is_write && offset == clint_mtimecmp_off_lp)
        mtimecmp_r <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.msg_type <= cmd_i.msg_type;
      resp_r.addr     <= cmd_i.addr;
      resp_r.lce_id   <= cmd_i.lce_id;
      resp_r.data     <= is_write ? '0 : rd_data;
    end
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

//--- hdl/loopback.sv
`timescale 1ns/1ps

module loopback
  import unicore_pkg::*;
(
  input  logic     clk_i
  , input  logic     rst_i

  , input  mem_msg_t cmd_i
  , input  logic     cmd_v_i
  , output logic     cmd_ready_o

  , output mem_msg_t resp_o
  , output logic     resp_v_o
  , input  logic     resp_yumi_i
);

  logic     resp_v_r;
  mem_msg_t resp_r;
  logic     cmd_fire;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_r <= 1'b0;
    else if (cmd_fire)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  // Unmapped space reads as zero and drops writes
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_r.msg_type <= cmd_i.msg_type;
      resp_r.addr     <= cmd_i.addr;
      resp_r.lce_id   <= cmd_i.lce_id;
      resp_r.data     <= '0;
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;

endmodule

//--- hdl/unicore_uncore.sv
`timescale 1ns/1ps

module unicore_uncore
  import unicore_pkg::*;
(
  input  logic     clk_i
  , input  logic     rst_i

  , input  mem_msg_t icache_cmd_i
  , input  logic     icache_cmd_v_i
  , output logic     icache_cmd_ready_o
  , output mem_msg_t icache_resp_o
  , output logic     icache_resp_v_o
  , input  logic     icache_resp_yumi_i

  , input  mem_msg_t dcache_cmd_i
  , input  logic     dcache_cmd_v_i
  , output logic     dcache_cmd_ready_o
  , output mem_msg_t dcache_resp_o
  , output logic     dcache_resp_v_o
  , input  logic     dcache_resp_yumi_i

  , input  mem_msg_t io_in_cmd_i
  , input  logic     io_in_cmd_v_i
  , output logic     io_in_cmd_ready_o
  , output mem_msg_t io_in_resp_o
  , output logic     io_in_resp_v_o
  , input  logic     io_in_resp_yumi_i

  , output mem_msg_t io_cmd_o
  , output logic     io_cmd_v_o
  , input  logic     io_cmd_ready_i
  , input  mem_msg_t io_resp_i
  , input  logic     io_resp_v_i
  , output logic     io_resp_yumi_o

  , output mem_msg_t mem_cmd_o
  , output logic     mem_cmd_v_o
  , input  logic     mem_cmd_ready_i
  , input  mem_msg_t mem_resp_i
  , input  logic     mem_resp_v_i
  , output logic     mem_resp_yumi_o

  , output logic     freeze_o
  , output logic     timer_irq_o
  , output logic     software_irq_o
);

  mem_msg_t [num_req_lp-1:0] req_cmd, req_resp, head;
  logic [num_req_lp-1:0]     req_cmd_v, req_cmd_ready, req_resp_v, req_resp_yumi;
  logic [num_req_lp-1:0]     head_v, head_yumi, rq_v, rq_ready;
  mem_msg_t                  routed_cmd, routed_resp;
  mem_msg_t [num_dev_lp-1:0] dev_resp;
  logic [num_dev_lp-1:0]     dev_v, dev_ready, dev_resp_v, dev_resp_yumi;

  // Requester ports onto the queue arrays
  assign req_cmd[req_icache_lp]   = icache_cmd_i;
  assign req_cmd_v[req_icache_lp] = icache_cmd_v_i;
  assign req_cmd[req_dcache_lp]   = dcache_cmd_i;
  assign req_cmd_v[req_dcache_lp] = dcache_cmd_v_i;
  assign req_cmd[req_io_lp]       = io_in_cmd_i;
  assign req_cmd_v[req_io_lp]     = io_in_cmd_v_i;

  assign icache_cmd_ready_o = req_cmd_ready[req_icache_lp];
  assign dcache_cmd_ready_o = req_cmd_ready[req_dcache_lp];
  assign io_in_cmd_ready_o  = req_cmd_ready[req_io_lp];

  assign icache_resp_o   = req_resp[req_icache_lp];
  assign icache_resp_v_o = req_resp_v[req_icache_lp];
  assign dcache_resp_o   = req_resp[req_dcache_lp];
  assign dcache_resp_v_o = req_resp_v[req_dcache_lp];
  assign io_in_resp_o    = req_resp[req_io_lp];
  assign io_in_resp_v_o  = req_resp_v[req_io_lp];

  assign req_resp_yumi[req_icache_lp] = icache_resp_yumi_i;
  assign req_resp_yumi[req_dcache_lp] = dcache_resp_yumi_i;
  assign req_resp_yumi[req_io_lp]     = io_in_resp_yumi_i;

  for (genvar i = 0; i < num_req_lp; i++)
  begin : req
    two_fifo cmd_fifo
    (
      .clk_i(clk_i), .rst_i(rst_i)
      , .data_i(req_cmd[i]), .v_i(req_cmd_v[i]), .ready_o(req_cmd_ready[i])
      , .data_o(head[i]), .v_o(head_v[i]), .yumi_i(head_yumi[i])
    );

    two_fifo resp_fifo
    (
      .clk_i(clk_i), .rst_i(rst_i)
      , .data_i(routed_resp), .v_i(rq_v[i]), .ready_o(rq_ready[i])
      , .data_o(req_resp[i]), .v_o(req_resp_v[i]), .yumi_i(req_resp_yumi[i])
    );
  end

  cmd_router cmd_rtr
  (
    .clk_i(clk_i), .rst_i(rst_i)
    , .head_i(head), .head_v_i(head_v), .head_yumi_o(head_yumi)
    , .dev_ready_i(dev_ready), .cmd_o(routed_cmd), .dev_v_o(dev_v)
  );

  resp_router resp_rtr
  (
    .clk_i(clk_i), .rst_i(rst_i)
    , .dev_resp_i(dev_resp), .dev_resp_v_i(dev_resp_v), .dev_resp_yumi_o(dev_resp_yumi)
    , .queue_ready_i(rq_ready), .resp_o(routed_resp), .queue_v_o(rq_v)
  );

  // The memory port is the direct path; outgoing I/O is a plain target
  assign io_cmd_o                = routed_cmd;
  assign io_cmd_v_o              = dev_v[e_dev_io];
  assign dev_ready[e_dev_io]     = io_cmd_ready_i;
  assign dev_resp[e_dev_io]      = io_resp_i;
  assign dev_resp_v[e_dev_io]    = io_resp_v_i;
  assign io_resp_yumi_o          = dev_resp_yumi[e_dev_io];

  assign mem_cmd_o               = routed_cmd;
  assign mem_cmd_v_o             = dev_v[e_dev_mem];
  assign dev_ready[e_dev_mem]    = mem_cmd_ready_i;
  assign dev_resp[e_dev_mem]     = mem_resp_i;
  assign dev_resp_v[e_dev_mem]   = mem_resp_v_i;
  assign mem_resp_yumi_o         = dev_resp_yumi[e_dev_mem];

  cfg_regs cfg
  (
    .clk_i(clk_i), .rst_i(rst_i)
    , .cmd_i(routed_cmd), .cmd_v_i(dev_v[e_dev_cfg]), .cmd_ready_o(dev_ready[e_dev_cfg])
    , .resp_o(dev_resp[e_dev_cfg]), .resp_v_o(dev_resp_v[e_dev_cfg])
    , .resp_yumi_i(dev_resp_yumi[e_dev_cfg])
    , .freeze_o(freeze_o)
  );

  clint_slice clint
  (
    .clk_i(clk_i), .rst_i(rst_i)
    , .cmd_i(routed_cmd), .cmd_v_i(dev_v[e_dev_clint]), .cmd_ready_o(dev_ready[e_dev_clint])
    , .resp_o(dev_resp[e_dev_clint]), .resp_v_o(dev_resp_v[e_dev_clint])
    , .resp_yumi_i(dev_resp_yumi[e_dev_clint])
    , .timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
  );

  loopback lpbk
  (
    .clk_i(clk_i), .rst_i(rst_i)
    , .cmd_i(routed_cmd), .cmd_v_i(dev_v[e_dev_loopback])
    , .cmd_ready_o(dev_ready[e_dev_loopback])
    , .resp_o(dev_resp[e_dev_loopback]), .resp_v_o(dev_resp_v[e_dev_loopback])
    , .resp_yumi_i(dev_resp_yumi[e_dev_loopback])
  );

endmodule

//--- tests/tb_unicore.sv
`timescale 1ns/1ps

module tb_unicore
  import unicore_pkg::*;
();

  // About ten times the length of the directed sequences below
  localparam int timeout_cycles_lp = 5000;

  logic     clk;
  logic     rst;
  logic     hold_mem;
  int       cycle_count;

  mem_msg_t cmd [num_req_lp];
  logic     cmd_v [num_req_lp];
  logic     cmd_ready [num_req_lp];
  mem_msg_t resp [num_req_lp];
  logic     resp_v [num_req_lp];
  logic     resp_yumi [num_req_lp];
  int       accepted [num_req_lp];

  mem_msg_t io_cmd, io_resp, mem_cmd, mem_resp;
  logic     io_cmd_v, io_cmd_ready, io_resp_v, io_resp_yumi;
  logic     mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_yumi;
  logic     freeze, timer_irq, software_irq;

  mem_msg_t    resp_q [num_req_lp][$];
  mem_msg_t    mem_log [$];
  mem_msg_t    io_log [$];
  mem_msg_t    mem_pend [$];
  mem_msg_t    io_pend [$];
  logic [63:0] store [logic [31:0]];

  unicore_uncore dut
  (
    .clk_i(clk), .rst_i(rst)
    , .icache_cmd_i(cmd[0]), .icache_cmd_v_i(cmd_v[0]), .icache_cmd_ready_o(cmd_ready[0])
    , .icache_resp_o(resp[0]), .icache_resp_v_o(resp_v[0]), .icache_resp_yumi_i(resp_yumi[0])
    , .dcache_cmd_i(cmd[1]), .dcache_cmd_v_i(cmd_v[1]), .dcache_cmd_ready_o(cmd_ready[1])
    , .dcache_resp_o(resp[1]), .dcache_resp_v_o(resp_v[1]), .dcache_resp_yumi_i(resp_yumi[1])
    , .io_in_cmd_i(cmd[2]), .io_in_cmd_v_i(cmd_v[2]), .io_in_cmd_ready_o(cmd_ready[2])
    , .io_in_resp_o(resp[2]), .io_in_resp_v_o(resp_v[2]), .io_in_resp_yumi_i(resp_yumi[2])
    , .io_cmd_o(io_cmd), .io_cmd_v_o(io_cmd_v), .io_cmd_ready_i(io_cmd_ready)
    , .io_resp_i(io_resp), .io_resp_v_i(io_resp_v), .io_resp_yumi_o(io_resp_yumi)
    , .mem_cmd_o(mem_cmd), .mem_cmd_v_o(mem_cmd_v), .mem_cmd_ready_i(mem_cmd_ready)
    , .mem_resp_i(mem_resp), .mem_resp_v_i(mem_resp_v), .mem_resp_yumi_o(mem_resp_yumi)
    , .freeze_o(freeze), .timer_irq_o(timer_irq), .software_irq_o(software_irq)
  );

  always #50 clk = ~clk;

  task automatic fail_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR: %s is 0x%0h, expected 0x%0h", name, got, exp);
      fail_run();
    end
  endtask

  function automatic string port_name(input int r);
    case (r)
      0: return "icache";
      1: return "dcache";
      default: return "io_in";
    endcase
  endfunction

  function automatic mem_msg_t make_msg(input int r, input msg_type_e t,
                                        input logic [31:0] addr, input logic [63:0] data);
    mem_msg_t m;
    m.msg_type = t;
    m.addr     = addr;
    m.lce_id   = lce_id_width_lp'(r);
    m.data     = data;
    return m;
  endfunction

  function automatic logic [31:0] local_addr(input logic [3:0] dev, input logic [15:0] off);
    return {8'h00, dev, 4'h0, off};
  endfunction

  // Unwritten model locations read as a pattern of the full address
  function automatic logic [63:0] fill_word(input logic [31:0] addr);
    return {addr ^ 32'hA5C3_0F69, ~addr};
  endfunction

  function automatic mem_msg_t burst_msg(input int r, input int k);
    return make_msg(r, e_mem_wr, 32'(dram_base_lp + (r << 12) + (k << 3)), {32'(r), 32'(k)});
  endfunction

  function automatic mem_msg_t model_answer(input mem_msg_t c);
    mem_msg_t a;
    a = c;
    if (c.msg_type == e_mem_wr)
    begin
      store[c.addr] = c.data;
      a.data        = '0;
    end
    else
      a.data = store.exists(c.addr) ? store[c.addr] : fill_word(c.addr);
    return a;
  endfunction

  // Memory and outgoing I/O models
  always @(posedge clk)
  begin
    if (mem_resp_v && mem_resp_yumi)
      void'(mem_pend.pop_front());
    if (io_resp_v && io_resp_yumi)
      void'(io_pend.pop_front());
    if (mem_cmd_v && mem_cmd_ready)
    begin
      mem_log.push_back(mem_cmd);
      mem_pend.push_back(model_answer(mem_cmd));
    end
    if (io_cmd_v && io_cmd_ready)
    begin
      io_log.push_back(io_cmd);
      io_pend.push_back(model_answer(io_cmd));
    end
  end

  always @(posedge clk)
  begin
    for (int r = 0; r < num_req_lp; r++)
    begin
      if (resp_v[r] && resp_yumi[r])
        resp_q[r].push_back(resp[r]);
    end
  end

  // Random ready and yumi patterns
  always @(negedge clk)
  begin
    mem_cmd_ready = !hold_mem && (($urandom % 4) != 0);
    io_cmd_ready  = (($urandom % 4) != 0);
    mem_resp_v    = (mem_pend.size() != 0);
    if (mem_resp_v)
      mem_resp = mem_pend[0];
    io_resp_v = (io_pend.size() != 0);
    if (io_resp_v)
      io_resp = io_pend[0];
    for (int r = 0; r < num_req_lp; r++)
    begin
      resp_yumi[r] = resp_v[r] && (($urandom % 4) != 0);
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles_lp)
    begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
      fail_run();
    end
  end

  a_stall_holds: assert property (@(posedge clk) disable iff (rst)
    (!mem_cmd_ready || !io_cmd_ready) |-> (!mem_cmd_v && !io_cmd_v))
  else
  begin
    $display("ERROR: dispatch during a target stall, mem_cmd_v_o 0x%0h io_cmd_v_o 0x%0h",
             mem_cmd_v, io_cmd_v);
    fail_run();
  end

  // Target responses are only taken while offered
  a_yumi_with_valid: assert property (@(posedge clk) disable iff (rst)
    (!mem_resp_yumi || mem_resp_v) && (!io_resp_yumi || io_resp_v))
  else
  begin
    $display("ERROR: yumi without valid, mem_resp_yumi_o 0x%0h io_resp_yumi_o 0x%0h",
             mem_resp_yumi, io_resp_yumi);
    fail_run();
  end

  task automatic send_cmd(input int r, input mem_msg_t m);
    @(negedge clk);
    cmd[r]   = m;
    cmd_v[r] = 1'b1;
    do
    begin
      @(posedge clk);
    end
    while (!cmd_ready[r]);
    accepted[r]++;
    @(negedge clk);
    cmd_v[r] = 1'b0;
  endtask

  task automatic take_resp(input int r, output mem_msg_t m);
    while (resp_q[r].size() == 0)
      @(negedge clk);
    m = resp_q[r].pop_front();
  endtask

  task automatic transact(input int r, input mem_msg_t m, output mem_msg_t rsp);
    send_cmd(r, m);
    take_resp(r, rsp);
    check_value({port_name(r), "_resp_o.lce_id"}, rsp.lce_id, r);
    check_value({port_name(r), "_resp_o.addr"}, rsp.addr, m.addr);
  endtask

  task automatic routed_access(input int r, input msg_type_e t, input logic [31:0] addr,
                               input logic [63:0] data, input bit to_mem,
                               output mem_msg_t rsp);
    int       n_mem;
    int       n_io;
    mem_msg_t sent;
    n_mem = mem_log.size();
    n_io  = io_log.size();
    sent  = make_msg(r, t, addr, data);
    transact(r, sent, rsp);
    check_value("mem_cmd_v_o count", mem_log.size(), n_mem + (to_mem ? 1 : 0));
    check_value("io_cmd_v_o count", io_log.size(), n_io + (to_mem ? 0 : 1));
    if (to_mem)
      check_value("mem_cmd_o", mem_log[$], sent);
    else
      check_value("io_cmd_o", io_log[$], sent);
  endtask

  task automatic burst_stream(input int r);
    for (int k = 0; k < 3; k++)
    begin
      send_cmd(r, burst_msg(r, k));
    end
  endtask

  initial
  begin
    mem_msg_t    rsp;
    mem_msg_t    m;
    logic [31:0] a;
    logic [63:0] d;
    logic [63:0] t0;
    int          r;
    int          kind;
    int          base;
    int          waited;
    int          next_k [num_req_lp];

    void'($urandom(78725));
    clk           = 1'b0;
    rst           = 1'b1;
    hold_mem      = 1'b0;
    cycle_count   = 0;
    mem_cmd_ready = 1'b0;
    io_cmd_ready  = 1'b0;
    mem_resp      = '0;
    mem_resp_v    = 1'b0;
    io_resp       = '0;
    io_resp_v     = 1'b0;
    for (int i = 0; i < num_req_lp; i++)
    begin
      cmd[i]       = '0;
      cmd_v[i]     = 1'b0;
      resp_yumi[i] = 1'b0;
      accepted[i]  = 0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < num_req_lp; i++)
    begin
      check_value({port_name(i), "_resp_v_o"}, resp_v[i], 0);
    end
    check_value("mem_cmd_v_o", mem_cmd_v, 0);
    check_value("io_cmd_v_o", io_cmd_v, 0);
    check_value("mem_resp_yumi_o", mem_resp_yumi, 0);
    check_value("io_resp_yumi_o", io_resp_yumi, 0);
    check_value("timer_irq_o", timer_irq, 0);
    check_value("software_irq_o", software_irq, 0);
    check_value("freeze_o", freeze, 1);

    // Freeze register, read, clear, read again
    a = local_addr(cfg_dev_lp, cfg_freeze_off_lp);
    transact(req_dcache_lp, make_msg(req_dcache_lp, e_mem_rd, a, '0), rsp);
    check_value("dcache_resp_o.data", rsp.data, 1);
    transact(req_dcache_lp, make_msg(req_dcache_lp, e_mem_wr, a, 64'h0), rsp);
    check_value("freeze_o", freeze, 0);
    transact(req_dcache_lp, make_msg(req_dcache_lp, e_mem_rd, a, '0), rsp);
    check_value("dcache_resp_o.data", rsp.data, 0);

    // CLINT
    a = local_addr(clint_dev_lp, clint_msip_off_lp);
    transact(req_dcache_lp, make_msg(req_dcache_lp, e_mem_wr, a, 64'h1), rsp);
    check_value("software_irq_o", software_irq, 1);
    check_value("timer_irq_o", timer_irq, 0);
    a = local_addr(clint_dev_lp, clint_mtimecmp_off_lp);
    transact(req_icache_lp, make_msg(req_icache_lp, e_mem_wr, a, 64'h40), rsp);
    waited = 0;
    while (!timer_irq && waited < 100)
    begin
      @(negedge clk);
      waited++;
    end
    check_value("timer_irq_o", timer_irq, 1);
    transact(req_io_lp, make_msg(req_io_lp, e_mem_rd, a, '0), rsp);
    check_value("io_in_resp_o.data", rsp.data, 64'h40);
    a = local_addr(clint_dev_lp, clint_mtime_off_lp);
    transact(req_dcache_lp, make_msg(req_dcache_lp, e_mem_rd, a, '0), rsp);
    t0 = rsp.data;
    transact(req_dcache_lp, make_msg(req_dcache_lp, e_mem_rd, a, '0), rsp);
    assert (rsp.data > t0)
    else
    begin
      $display("ERROR: dcache_resp_o.data mtime 0x%0h did not pass 0x%0h", rsp.data, t0);
      fail_run();
    end

    // Decode to memory and outgoing I/O; kinds are DRAM, cache, boot, host
    for (int i = 0; i < 16; i++)
    begin
      r    = $urandom % num_req_lp;
      kind = $urandom % 4;
      a    = $urandom;
      if (kind == 0)
        a[31] = 1'b1;
      else
      begin
        a[31]    = 1'b0;
        a[23:20] = (kind == 1) ? cache_dev_lp : (kind == 2) ? boot_dev_lp : host_dev_lp;
      end
      d = {$urandom, $urandom};
      routed_access(r, e_mem_rd, a, '0, kind < 2, rsp);
      check_value({port_name(r), "_resp_o.data"}, rsp.data, fill_word(a));
      routed_access(r, e_mem_wr, a, d, kind < 2, rsp);
      routed_access(r, e_mem_rd, a, '0, kind < 2, rsp);
      check_value({port_name(r), "_resp_o.data"}, rsp.data, d);
    end

    // Unmapped local devices
    for (int i = 0; i < num_req_lp; i++)
    begin
      a        = $urandom;
      a[31]    = 1'b0;
      a[23:20] = (i == 0) ? 4'd7 : 4'(5 + $urandom % 11);
      transact(i, make_msg(i, e_mem_rd, a, '0), rsp);
      check_value({port_name(i), "_resp_o.data"}, rsp.data, 0);
    end

    // Memory back-pressure with all three requesters
    base = mem_log.size();
    for (int i = 0; i < num_req_lp; i++)
    begin
      accepted[i] = 0;
      next_k[i]   = 0;
    end
    @(posedge clk);
    hold_mem = 1'b1;
    fork
      burst_stream(req_icache_lp);
      burst_stream(req_dcache_lp);
      burst_stream(req_io_lp);
      begin
        while (accepted[0] < 2 || accepted[1] < 2 || accepted[2] < 2)
          @(negedge clk);
        repeat (8) @(negedge clk);
        for (int i = 0; i < num_req_lp; i++)
        begin
          check_value({port_name(i), " accepted commands"}, accepted[i], 2);
          check_value({port_name(i), "_cmd_ready_o"}, cmd_ready[i], 0);
        end
        check_value("mem_cmd_v_o count", mem_log.size(), base);
        @(posedge clk);
        hold_mem = 1'b0;
      end
    join
    for (int i = 0; i < 3 * num_req_lp; i++)
    begin
      take_resp(i % num_req_lp, rsp);
      check_value({port_name(i % num_req_lp), "_resp_o.lce_id"}, rsp.lce_id, i % num_req_lp);
    end
    check_value("mem_cmd_v_o count", mem_log.size(), base + 3 * num_req_lp);
    for (int i = base; i < mem_log.size(); i++)
    begin
      m = mem_log[i];
      r = m.lce_id;
      check_value("mem_cmd_o", m, burst_msg(r, next_k[r]));
      next_k[r]++;
    end
    for (int i = 0; i < num_req_lp; i++)
    begin
      check_value({port_name(i), " commands on mem_cmd_o"}, next_k[i], 3);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- compile.f
hdl/unicore_pkg.sv
hdl/two_fifo.sv
hdl/cmd_router.sv
hdl/resp_router.sv
hdl/cfg_regs.sv
hdl/clint_slice.sv
hdl/loopback.sv
hdl/unicore_uncore.sv
tests/tb_unicore.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the uncore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_unicore -f compile.f -o tb_unicore > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_unicore > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
exit 0
